//--- cache_front_defines.svh
`ifndef CACHE_FRONT_DEFINES_SVH
`define CACHE_FRONT_DEFINES_SVH

// --------------------
// Data path
// --------------------
`define CF_DATA_W      32
`define CF_BYTE_W      4   // Bytes per word
`define CF_OFS_W       2   // Byte offset in word

// --------------------
// Bus fields
// --------------------
`define CF_ADDR_W      16  // Cache word address
`define CF_PFX_W       2   // Uncached prefix
`define CF_XADR_W      20  // Prefix + word address + offset
`define CF_TYP_W       3
`define CF_ATR_W       3
`define CF_SIZ_W       8
`define CF_SEQ_W       4
`define CF_NUM_SEQ     16

// Miss queue
`define CF_MQ_DEPTH    16
`define CF_MQ_DEPTH_W  4

`endif

//--- cache_front_pkg.sv
`default_nettype none

`include "cache_front_defines.svh"

package cache_front_pkg;

  // --------------------
  // Bus encodings
  // --------------------
  localparam logic [`CF_TYP_W-1:0] TYP_WRITE = 'd0;
  localparam logic [`CF_TYP_W-1:0] TYP_READ  = 'd1;
  localparam logic [`CF_TYP_W-1:0] TYP_RSVD  = 'd4;

  localparam int ATR_C_ACK  = 0;  // Command attr bits
  localparam int ATR_C_CCH  = 1;
  localparam int ATR_R_LAST = 0;  // Response attr bits
  localparam int ATR_R_AERR = 1;
  localparam int ATR_R_DERR = 2;
  localparam int ATR_D_LAST = 0;  // Data attr bit

  typedef struct packed {
    logic [`CF_TYP_W-1:0]  typ;
    logic [`CF_ATR_W-1:0]  attr;
    logic [`CF_SIZ_W-1:0]  size;
    logic [`CF_SEQ_W-1:0]  id;
    logic [`CF_XADR_W-1:0] addr;
  } nx_cmd_t;

  typedef struct packed {
    logic [`CF_SEQ_W-1:0]  id;
    logic [`CF_DATA_W-1:0] data;
    logic [`CF_ATR_W-1:0]  attr;
  } nx_rsp_t;

  // Bus address, cached or uncached view
  typedef union packed {
    struct packed {
      logic [`CF_PFX_W-1:0]  pfx;
      logic [`CF_ADDR_W-1:0] addr;
      logic [`CF_OFS_W-1:0]  ofs;
    } cached_v;
    struct packed {
      logic [`CF_PFX_W-1:0]           pfx;
      logic [`CF_ADDR_W+`CF_OFS_W-1:0] wofs;  // Word address and offset
    } ucach_v;
  } xaddr_u;

  typedef struct packed {
    logic                  read;
    logic                  write;
    logic                  ucach;
    logic [`CF_OFS_W-1:0]  ucofst;
    logic [`CF_SIZ_W-1:0]  ucsize;
    logic [`CF_PFX_W-1:0]  ucpfx;
    logic [`CF_SEQ_W-1:0]  seq;
    logic [`CF_ADDR_W-1:0] addr;
    logic [`CF_BYTE_W-1:0] byin;
    logic [`CF_DATA_W-1:0] din;
  } t1_req_t;

  typedef struct packed {
    logic                  vld;
    logic                  serr;
    logic [`CF_SEQ_W-1:0]  seq;
    logic [`CF_DATA_W-1:0] dout;
    logic [`CF_ATR_W-1:0]  attr;
  } t1_rsp_t;

  typedef struct packed {
    logic                  read;
    logic                  write;
    logic                  ucach;
    logic [`CF_OFS_W-1:0]  ucofst;
    logic [`CF_SIZ_W-1:0]  ucsize;
    logic [`CF_PFX_W-1:0]  ucpfx;
    logic [`CF_SEQ_W-1:0]  seq;
    logic [`CF_ADDR_W-1:0] addr;
    logic [`CF_DATA_W-1:0] din;
  } t2_req_t;

  typedef struct packed {
    logic                  vld;
    logic [`CF_SEQ_W-1:0]  seq;
    logic [`CF_DATA_W-1:0] dout;
    logic [`CF_ATR_W-1:0]  attr;
  } t2_rsp_t;

  typedef struct packed {
    nx_cmd_t               cmd;
    logic [`CF_DATA_W-1:0] data;
    logic                  write;
    logic                  read;
    logic                  lack;   // Local ack on issue
  } mq_entry_t;

endpackage

`default_nettype wire

//--- sreq_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_front_defines.svh"

module sreq_decode (
  input  wire                          s_creq_valid,
  input  wire cache_front_pkg::nx_cmd_t s_creq,
  input  wire                          s_dreq_valid,
  input  wire [`CF_DATA_W-1:0]         s_dreq_data,
  input  wire [`CF_ATR_W-1:0]          s_dreq_attr,
  input  wire                          t1_stall,
  input  wire                          seq_free,
  input  wire [`CF_SEQ_W-1:0]          seq_alloc,
  output logic                         s_stall,
  output logic                         take,
  output logic                         take_ack,
  output cache_front_pkg::t1_req_t     t1_req
);

  import cache_front_pkg::*;

  logic                   cmd_rd;
  logic                   cmd_wr;
  logic [`CF_BYTE_W-1:0]  byte_run;
  logic [`CF_XADR_W-1:0]  word_addr;

  assign s_stall = !seq_free || t1_stall;

  assign cmd_rd = s_creq_valid && !s_stall && (s_creq.typ == TYP_READ);
  assign cmd_wr = s_creq_valid && !s_stall && (s_creq.typ == TYP_WRITE) &&
                  s_dreq_valid && s_dreq_attr[ATR_D_LAST];  // Data beat complete

  assign take     = cmd_rd || cmd_wr;
  assign take_ack = s_creq.attr[ATR_C_ACK];

  assign byte_run  = ~({`CF_BYTE_W{1'b1}} << s_creq.size);  // size ones
  assign word_addr = s_creq.addr >> `CF_OFS_W;

  // --------------------
  // Cache request
  // --------------------
  always_comb begin
    t1_req.read   = cmd_rd;
    t1_req.write  = cmd_wr;
    t1_req.ucach  = !s_creq.attr[ATR_C_CCH];
    t1_req.ucofst = s_creq.addr[`CF_OFS_W-1:0];
    t1_req.ucsize = s_creq.size;
    t1_req.ucpfx  = s_creq.addr[`CF_XADR_W-1 -: `CF_PFX_W];
    t1_req.seq    = seq_alloc;
    t1_req.addr   = word_addr[`CF_ADDR_W-1:0];
    t1_req.byin   = byte_run << s_creq.addr[`CF_OFS_W-1:0];
    t1_req.din    = s_dreq_data;
  end

endmodule

`default_nettype wire

//--- seq_tracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_front_defines.svh"

module seq_tracker (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          take,
  input  wire [`CF_SEQ_W-1:0]          take_fid,
  input  wire                          take_ack,
  output logic [`CF_SEQ_W-1:0]         seq_alloc,
  output logic                         seq_free,
  input  wire cache_front_pkg::t1_rsp_t t1_rsp,
  input  wire [`CF_SEQ_W-1:0]          t2_seq,
  output logic                         t2_seq_ack,
  output logic                         s_rreq_valid,
  output cache_front_pkg::nx_rsp_t     s_rreq,
  output logic                         e_l2err_vld
);

  import cache_front_pkg::*;

  logic [`CF_NUM_SEQ-1:0] busy;
  logic [`CF_NUM_SEQ-1:0] ack_vec;
  logic [`CF_SEQ_W-1:0]   fid_tab [`CF_NUM_SEQ];

  logic                   rsp_derr;
  logic [`CF_ATR_W-1:0]   rsp_attr;
  logic                   rsp_ack;

  // --------------------
  // Allocation
  // --------------------
  always_comb begin
    seq_free  = 1'b0;
    seq_alloc = '0;
    for (int i = `CF_NUM_SEQ-1; i >= 0; i--) begin
      if (!busy[i]) begin
        seq_free  = 1'b1;
        seq_alloc = i[`CF_SEQ_W-1:0];  // Lowest wins
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= '0;
      ack_vec <= '0;
    end else begin
      if (take) begin
        busy[seq_alloc]    <= 1'b1;
        ack_vec[seq_alloc] <= take_ack;
      end
      if (t1_rsp.vld)
        busy[t1_rsp.seq] <= 1'b0;  // Free from next cycle
    end
  end

  always_ff @(posedge clk) begin
    if (take)
      fid_tab[seq_alloc] <= take_fid;
  end

  assign t2_seq_ack = ack_vec[t2_seq];

  // --------------------
  // Response to CPU
  // --------------------
  assign rsp_ack  = ack_vec[t1_rsp.seq];
  assign rsp_derr = t1_rsp.serr && !(|t1_rsp.attr);

  always_comb begin
    rsp_attr = t1_rsp.attr;
    rsp_attr[ATR_R_LAST] = 1'b1;
    if (rsp_derr)
      rsp_attr[ATR_R_DERR] = 1'b1;  // Cache data error
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s_rreq_valid <= 1'b0;
      e_l2err_vld  <= 1'b0;
    end else begin
      s_rreq_valid <= t1_rsp.vld && rsp_ack;
      // L2 error with nobody to tell
      e_l2err_vld  <= t1_rsp.vld && (t1_rsp.attr[ATR_R_AERR] || t1_rsp.attr[ATR_R_DERR]) &&
                      !rsp_ack;
    end
  end

  always_ff @(posedge clk) begin
    s_rreq.id   <= fid_tab[t1_rsp.seq];
    s_rreq.data <= t1_rsp.dout;
    s_rreq.attr <= rsp_attr;
  end

endmodule

`default_nettype wire

//--- mreq_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_front_defines.svh"

module mreq_fifo (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             push,
  input  wire cache_front_pkg::mq_entry_t push_data,
  input  wire                             pop,
  output cache_front_pkg::mq_entry_t      pop_data,
  output logic                            full,
  output logic                            empty
);

  import cache_front_pkg::*;

  mq_entry_t                  mem [`CF_MQ_DEPTH];
  logic [`CF_MQ_DEPTH_W-1:0]  wr_ptr;
  logic [`CF_MQ_DEPTH_W-1:0]  rd_ptr;
  logic [`CF_MQ_DEPTH_W:0]    count;

  assign full     = (count == `CF_MQ_DEPTH);
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];  // Show-ahead head

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

endmodule

`default_nettype wire

//--- mreq_issue.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_front_defines.svh"

module mreq_issue (
  input  wire                          clk,
  input  wire                          rst,
  input  wire cache_front_pkg::t2_req_t t2_req,
  input  wire                          t2_seq_ack,
  input  wire                          t2_stall,
  input  wire                          m_creq_rdstall,
  input  wire                          m_creq_wrstall,
  input  wire                          m_dreq_stall,
  output logic                         m_creq_valid,
  output cache_front_pkg::nx_cmd_t     m_creq,
  output logic                         m_dreq_valid,
  output logic [`CF_DATA_W-1:0]        m_dreq_data,
  input  wire                          m_rreq_valid,
  input  wire cache_front_pkg::nx_rsp_t m_rreq,
  output logic                         m_rreq_stall,
  output cache_front_pkg::t2_rsp_t     t2_rsp,
  output logic                         mfifo_empty
);

  import cache_front_pkg::*;

  localparam logic [`CF_ATR_W-1:0] ERR_MASK = (1 << ATR_R_AERR) | (1 << ATR_R_DERR);

  mq_entry_t  ent;
  mq_entry_t  head;
  xaddr_u     xa;
  logic       mq_push;
  logic       mq_pop;
  logic       mq_full;
  logic       lack_vld;

  // --------------------
  // Push side
  // --------------------
  always_comb begin
    xa = '0;
    if (t2_req.ucach) begin
      xa.ucach_v.pfx  = t2_req.ucpfx;
      xa.ucach_v.wofs = {t2_req.addr, t2_req.ucofst};
    end else begin
      xa.cached_v.addr = t2_req.addr;
      xa.cached_v.ofs  = '0;  // Line aligned
    end
  end

  always_comb begin
    ent = '0;
    ent.cmd.typ  = t2_req.read ? TYP_READ : (t2_req.write ? TYP_WRITE : TYP_RSVD);
    ent.cmd.size = t2_req.ucach ? t2_req.ucsize : `CF_SIZ_W'(`CF_BYTE_W);
    ent.cmd.id   = t2_req.seq;
    ent.cmd.addr = xa;
    ent.cmd.attr[ATR_C_CCH] = !t2_req.ucach;
    ent.cmd.attr[ATR_C_ACK] = t2_req.read || (t2_req.write && t2_req.ucach && t2_seq_ack);
    ent.data  = t2_req.write ? t2_req.din : '0;
    ent.write = t2_req.write;
    ent.read  = t2_req.read;
    ent.lack  = t2_req.write && t2_req.ucach && !t2_seq_ack;
  end

  assign mq_push = (t2_req.read || t2_req.write) && !mq_full;

  mreq_fifo i_mreq_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (mq_push),
    .push_data (ent),
    .pop       (mq_pop),
    .pop_data  (head),
    .full      (mq_full),
    .empty     (mfifo_empty)
  );

  // --------------------
  // Pop side
  // --------------------
  assign mq_pop = !mfifo_empty &&
                  ((head.read && !m_creq_rdstall) ||
                   (head.write && !m_creq_wrstall && !m_dreq_stall));

  assign m_creq_valid = mq_pop;
  assign m_creq       = head.cmd;
  assign m_dreq_valid = mq_pop && head.write;
  assign m_dreq_data  = head.data;

  assign lack_vld     = mq_pop && head.lack;
  assign m_rreq_stall = lack_vld || t2_stall;  // Local ack owns the return

  always_comb begin
    t2_rsp.vld  = (lack_vld || m_rreq_valid) && !t2_stall;
    t2_rsp.dout = m_rreq.data;
    if (lack_vld) begin
      t2_rsp.seq  = head.cmd.id;
      t2_rsp.attr = '0;
      t2_rsp.attr[ATR_R_LAST] = 1'b1;
    end else begin
      t2_rsp.seq  = m_rreq.id;
      t2_rsp.attr = m_rreq.attr & ERR_MASK;
    end
  end

endmodule

`default_nettype wire

//--- cache_front_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_front_defines.svh"

module cache_front_top (
  input  wire                           clk,
  input  wire                           rst,
  // CPU side
  input  wire                           s_creq_valid,
  input  wire cache_front_pkg::nx_cmd_t s_creq,
  input  wire                           s_dreq_valid,
  input  wire [`CF_DATA_W-1:0]          s_dreq_data,
  input  wire [`CF_ATR_W-1:0]           s_dreq_attr,
  output wire                           s_stall,
  output wire                           s_rreq_valid,
  output wire cache_front_pkg::nx_rsp_t s_rreq,
  // Cache
  output wire cache_front_pkg::t1_req_t t1_req,
  input  wire cache_front_pkg::t1_rsp_t t1_rsp,
  input  wire                           t1_stall,
  input  wire cache_front_pkg::t2_req_t t2_req,
  output wire cache_front_pkg::t2_rsp_t t2_rsp,
  input  wire                           t2_stall,
  // L2 side
  output wire                           m_creq_valid,
  output wire cache_front_pkg::nx_cmd_t m_creq,
  input  wire                           m_creq_rdstall,
  input  wire                           m_creq_wrstall,
  output wire                           m_dreq_valid,
  output wire [`CF_DATA_W-1:0]          m_dreq_data,
  input  wire                           m_dreq_stall,
  input  wire                           m_rreq_valid,
  input  wire cache_front_pkg::nx_rsp_t m_rreq,
  output wire                           m_rreq_stall,
  output wire                           e_l2err_vld,
  output wire                           mfifo_empty
);

  wire                  take;
  wire                  take_ack;
  wire                  seq_free;
  wire [`CF_SEQ_W-1:0]  seq_alloc;
  wire                  t2_seq_ack;

  sreq_decode i_sreq_decode (
    .s_creq_valid (s_creq_valid),
    .s_creq       (s_creq),
    .s_dreq_valid (s_dreq_valid),
    .s_dreq_data  (s_dreq_data),
    .s_dreq_attr  (s_dreq_attr),
    .t1_stall     (t1_stall),
    .seq_free     (seq_free),
    .seq_alloc    (seq_alloc),
    .s_stall      (s_stall),
    .take         (take),
    .take_ack     (take_ack),
    .t1_req       (t1_req)
  );

  seq_tracker i_seq_tracker (
    .clk          (clk),
    .rst          (rst),
    .take         (take),
    .take_fid     (s_creq.id),  // Foreign id
    .take_ack     (take_ack),
    .seq_alloc    (seq_alloc),
    .seq_free     (seq_free),
    .t1_rsp       (t1_rsp),
    .t2_seq       (t2_req.seq),
    .t2_seq_ack   (t2_seq_ack),
    .s_rreq_valid (s_rreq_valid),
    .s_rreq       (s_rreq),
    .e_l2err_vld  (e_l2err_vld)
  );

  mreq_issue i_mreq_issue (
    .clk            (clk),
    .rst            (rst),
    .t2_req         (t2_req),
    .t2_seq_ack     (t2_seq_ack),
    .t2_stall       (t2_stall),
    .m_creq_rdstall (m_creq_rdstall),
    .m_creq_wrstall (m_creq_wrstall),
    .m_dreq_stall   (m_dreq_stall),
    .m_creq_valid   (m_creq_valid),
    .m_creq         (m_creq),
    .m_dreq_valid   (m_dreq_valid),
    .m_dreq_data    (m_dreq_data),
    .m_rreq_valid   (m_rreq_valid),
    .m_rreq         (m_rreq),
    .m_rreq_stall   (m_rreq_stall),
    .t2_rsp         (t2_rsp),
    .mfifo_empty    (mfifo_empty)
  );

endmodule

`default_nettype wire

//--- cache_front_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_front_defines.svh"

module cache_front_properties (
  input wire                         clk,
  input wire                         rst,
  input wire                         push,
  input wire                         full,
  input wire                         m_creq_valid,
  input wire [`CF_TYP_W-1:0]         creq_typ,
  input wire                         m_creq_rdstall,
  input wire                         m_creq_wrstall,
  input wire                         m_dreq_stall,
  input wire [`CF_NUM_SEQ-1:0]       busy,
  input wire                         s_stall
);

  import cache_front_pkg::*;

  // --------------------
  // Miss FIFO
  // --------------------
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("Miss FIFO pushed while full");

  a_rd_stall: assert property (@(posedge clk) disable iff (rst)
    (m_creq_valid && creq_typ == TYP_READ) |-> !m_creq_rdstall)
    else $error("L2 read issued under read stall");

  a_wr_stall: assert property (@(posedge clk) disable iff (rst)
    (m_creq_valid && creq_typ == TYP_WRITE) |-> (!m_creq_wrstall && !m_dreq_stall))
    else $error("L2 write issued under write stall");

  a_ids_full: assert property (@(posedge clk) disable iff (rst) (&busy) |-> s_stall)
    else $error("CPU side not stalled with all ids busy");

endmodule

bind cache_front_top cache_front_properties i_cache_front_properties (
  .clk            (clk),
  .rst            (rst),
  .push           (t2_req.read || t2_req.write),
  .full           (i_mreq_issue.mq_full),
  .m_creq_valid   (m_creq_valid),
  .creq_typ       (m_creq.typ),
  .m_creq_rdstall (m_creq_rdstall),
  .m_creq_wrstall (m_creq_wrstall),
  .m_dreq_stall   (m_dreq_stall),
  .busy           (i_seq_tracker.busy),
  .s_stall        (s_stall)
);

`default_nettype wire

//--- cache_front_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_front_defines.svh"

module cache_front_checker (
  input wire                           clk,
  input wire                           rst,
  input wire                           s_creq_valid,
  input wire cache_front_pkg::nx_cmd_t s_creq,
  input wire                           s_dreq_valid,
  input wire [`CF_DATA_W-1:0]          s_dreq_data,
  input wire [`CF_ATR_W-1:0]           s_dreq_attr,
  input wire                           s_stall,
  input wire                           s_rreq_valid,
  input wire cache_front_pkg::nx_rsp_t s_rreq,
  input wire cache_front_pkg::t1_req_t t1_req,
  input wire cache_front_pkg::t1_rsp_t t1_rsp,
  input wire                           t1_stall,
  input wire cache_front_pkg::t2_req_t t2_req,
  input wire cache_front_pkg::t2_rsp_t t2_rsp,
  input wire                           t2_stall,
  input wire                           m_creq_valid,
  input wire cache_front_pkg::nx_cmd_t m_creq,
  input wire                           m_creq_rdstall,
  input wire                           m_creq_wrstall,
  input wire                           m_dreq_valid,
  input wire [`CF_DATA_W-1:0]          m_dreq_data,
  input wire                           m_dreq_stall,
  input wire                           m_rreq_valid,
  input wire cache_front_pkg::nx_rsp_t m_rreq,
  input wire                           m_rreq_stall,
  input wire                           e_l2err_vld,
  input wire                           mfifo_empty
);

  import cache_front_pkg::*;

  int                     err_count = 0;
  logic [`CF_NUM_SEQ-1:0] busy;     // Model of outstanding ids
  logic [`CF_NUM_SEQ-1:0] ack;
  logic [`CF_SEQ_W-1:0]   fid [`CF_NUM_SEQ];
  mq_entry_t              l2q [$];  // Model of the L2 queue
  logic                   exp_rv;
  logic                   exp_ev;
  nx_rsp_t                exp_rsp;

  task automatic check(input bit ok, input string msg);
    if (!ok) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
    end
  endtask

  task automatic check_cpu_side();
    int         low;
    int         ofs;
    logic       exp_take;
    logic       is_rd;
    logic [3:0] be;
    logic [2:0] a;
    low = -1;
    for (int i = `CF_NUM_SEQ-1; i >= 0; i--)
      if (!busy[i]) low = i;
    check(s_rreq_valid == exp_rv, "s_rreq_valid mismatch");
    if (exp_rv) check(s_rreq == exp_rsp, "s_rreq id, data or attr mismatch");
    check(e_l2err_vld == exp_ev, "e_l2err_vld mismatch");
    check(s_stall == (low < 0 || t1_stall), "s_stall mismatch");
    is_rd = (s_creq.typ == TYP_READ);
    exp_take = s_creq_valid && !(low < 0 || t1_stall) &&
               (is_rd || (s_creq.typ == TYP_WRITE && s_dreq_valid && s_dreq_attr[0]));
    check(t1_req.read == (exp_take && is_rd), "t1_req.read mismatch");
    check(t1_req.write == (exp_take && !is_rd), "t1_req.write mismatch");
    if (exp_take) begin
      ofs = int'(s_creq.addr[1:0]);
      for (int b = 0; b < 4; b++)
        be[b] = (b >= ofs) && (b - ofs < int'(s_creq.size));
      check(t1_req.seq == low[3:0], "t1_req.seq is not the lowest free id");
      check(t1_req.ucach == !s_creq.attr[1], "t1_req.ucach mismatch");
      check(t1_req.ucofst == s_creq.addr[1:0], "t1_req.ucofst mismatch");
      check(t1_req.ucsize == s_creq.size, "t1_req.ucsize mismatch");
      check(t1_req.ucpfx == s_creq.addr[19:18], "t1_req.ucpfx mismatch");
      check(t1_req.byin == be, "t1_req.byin mismatch");
      check(t1_req.addr == s_creq.addr[17:2], "t1_req.addr mismatch");
      if (!is_rd) check(t1_req.din == s_dreq_data, "t1_req.din mismatch");
      busy[low] = 1'b1;
      fid[low]  = s_creq.id;
      ack[low]  = s_creq.attr[0];
    end
    // Reply expected one cycle later
    a = t1_rsp.attr | 3'b001;
    if (t1_rsp.serr && t1_rsp.attr == 3'b000) a[2] = 1'b1;
    exp_rv  = t1_rsp.vld && ack[t1_rsp.seq];
    exp_ev  = t1_rsp.vld && (t1_rsp.attr[2:1] != 2'b00) && !ack[t1_rsp.seq];
    exp_rsp = '{id: fid[t1_rsp.seq], data: t1_rsp.dout, attr: a};
    if (t1_rsp.vld) busy[t1_rsp.seq] = 1'b0;
  endtask

  task automatic check_l2_side();
    int        qn;
    logic      exp_pop;
    mq_entry_t h;
    mq_entry_t e;
    qn = l2q.size();
    h  = '0;
    exp_pop = (qn > 0) && ((l2q[0].read && !m_creq_rdstall) ||
              (l2q[0].write && !m_creq_wrstall && !m_dreq_stall));
    check(mfifo_empty == (qn == 0), "mfifo_empty mismatch");
    check(m_creq_valid == exp_pop, "m_creq_valid mismatch");
    if (exp_pop) begin
      h = l2q.pop_front();
      check(m_creq == h.cmd, "m_creq command mismatch");
      check(m_dreq_valid == h.write, "m_dreq_valid mismatch");
      if (h.write) check(m_dreq_data == h.data, "m_dreq_data mismatch");
    end else begin
      check(!m_dreq_valid, "m_dreq_valid without a command");
    end
    if (exp_pop && h.lack) begin
      check(m_rreq_stall, "m_rreq_stall low during local ack");
      check(t2_rsp.vld == !t2_stall, "local ack t2_rsp.vld mismatch");
      if (!t2_stall)
        check(t2_rsp.seq == h.cmd.id && t2_rsp.attr == 3'b001, "local ack seq or attr");
    end else begin
      check(m_rreq_stall == t2_stall, "m_rreq_stall mismatch");
      check(t2_rsp.vld == (m_rreq_valid && !t2_stall), "t2_rsp.vld mismatch");
      if (t2_rsp.vld)
        check(t2_rsp.seq == m_rreq.id && t2_rsp.dout == m_rreq.data &&
              t2_rsp.attr == (m_rreq.attr & 3'b110), "t2_rsp return mismatch");
    end
    if ((t2_req.read || t2_req.write) && qn < `CF_MQ_DEPTH) begin
      e = '0;
      e.cmd.typ  = t2_req.read ? TYP_READ : TYP_WRITE;
      e.cmd.size = t2_req.ucach ? t2_req.ucsize : 8'd4;
      e.cmd.id   = t2_req.seq;
      e.cmd.addr = t2_req.ucach ? {t2_req.ucpfx, t2_req.addr, t2_req.ucofst} :
                                  {2'b00, t2_req.addr, 2'b00};
      e.cmd.attr[1] = !t2_req.ucach;
      e.cmd.attr[0] = t2_req.read || (t2_req.ucach && ack[t2_req.seq]);
      e.data  = t2_req.write ? t2_req.din : '0;
      e.write = t2_req.write;
      e.read  = t2_req.read;
      e.lack  = t2_req.write && t2_req.ucach && !ack[t2_req.seq];
      l2q.push_back(e);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      busy   = '0;
      ack    = '0;
      exp_rv = 1'b0;
      exp_ev = 1'b0;
      l2q.delete();
    end else begin
      check_l2_side();  // Uses ack state from before this edge
      check_cpu_side();
    end
  end

endmodule

`default_nettype wire

//--- tb_cache_front.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_front_defines.svh"

module tb_cache_front;

  import cache_front_pkg::*;

  localparam int NUM_CMDS   = 3000;
  localparam int MAX_CYCLES = NUM_CMDS * 10;

  logic                  clk;
  logic                  rst;
  logic                  s_creq_valid;
  nx_cmd_t               s_creq;
  logic                  s_dreq_valid;
  logic [`CF_DATA_W-1:0] s_dreq_data;
  logic [`CF_ATR_W-1:0]  s_dreq_attr;
  wire                   s_stall;
  wire                   s_rreq_valid;
  nx_rsp_t               s_rreq;
  t1_req_t               t1_req;
  t1_rsp_t               t1_rsp;
  logic                  t1_stall;
  t2_req_t               t2_req;
  t2_rsp_t               t2_rsp;
  logic                  t2_stall;
  wire                   m_creq_valid;
  nx_cmd_t               m_creq;
  logic                  m_creq_rdstall;
  logic                  m_creq_wrstall;
  wire                   m_dreq_valid;
  wire [`CF_DATA_W-1:0]  m_dreq_data;
  logic                  m_dreq_stall;
  logic                  m_rreq_valid;
  nx_rsp_t               m_rreq;
  wire                   m_rreq_stall;
  wire                   e_l2err_vld;
  wire                   mfifo_empty;

  int   accepted = 0;
  int   cycles = 0;
  logic take_seen = 1'b0;
  logic [`CF_SEQ_W-1:0] pend [$];  // Ids the cache model still owes

  cache_front_top i_cache_front_top (.*);
  cache_front_checker i_checker (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive_cpu();
    if (s_creq_valid && take_seen) accepted++;
    if (s_creq_valid && !take_seen) begin
      // Hold the command, the write beat may complete later
      if (s_creq.typ == TYP_WRITE) begin
        s_dreq_valid = ($urandom_range(3) != 0);
        s_dreq_attr  = ($urandom_range(7) != 0) ? 3'b001 : 3'b000;
      end
      return;
    end
    s_creq_valid = (accepted < NUM_CMDS) && ($urandom_range(3) != 0);
    s_creq.typ   = $urandom_range(1) ? TYP_READ : TYP_WRITE;
    s_creq.attr  = 3'($urandom_range(7));
    s_creq.size  = 8'($urandom_range(4, 1));
    s_creq.id    = 4'($urandom);
    s_creq.addr  = 20'($urandom);
    s_dreq_valid = (s_creq.typ == TYP_WRITE) && ($urandom_range(3) != 0);
    s_dreq_attr  = ($urandom_range(7) != 0) ? 3'b001 : 3'b000;
    s_dreq_data  = $urandom;
  endtask

  task automatic drive_cache();
    int idx;
    t1_stall = ($urandom_range(7) == 0);
    t1_rsp   = '0;
    // Slow phases let all ids fill up
    if (pend.size() > 0 && (cycles % 600) > 80 && $urandom_range(2) == 0) begin
      idx = $urandom_range(pend.size() - 1);
      t1_rsp.vld  = 1'b1;
      t1_rsp.seq  = pend[idx];
      t1_rsp.dout = $urandom;
      t1_rsp.attr = ($urandom_range(5) == 0) ? 3'($urandom_range(7)) : 3'b000;
      t1_rsp.serr = ($urandom_range(9) == 0);
      pend.delete(idx);
    end
  endtask

  task automatic drive_l2();
    t2_req = '0;
    if ($urandom_range(2) == 0) begin
      t2_req.read   = $urandom_range(1) == 1;
      t2_req.write  = !t2_req.read;
      t2_req.ucach  = $urandom_range(1) == 1;
      t2_req.ucofst = 2'($urandom);
      t2_req.ucsize = 8'($urandom_range(4, 1));
      t2_req.ucpfx  = 2'($urandom);
      t2_req.seq    = 4'($urandom);
      t2_req.addr   = 16'($urandom);
      t2_req.din    = $urandom;
    end
    t2_stall       = ($urandom_range(5) == 0);
    m_creq_rdstall = ($urandom_range(3) == 0);
    m_creq_wrstall = ($urandom_range(3) == 0);
    m_dreq_stall   = ($urandom_range(4) == 0);
    m_rreq_valid   = ($urandom_range(2) == 0);
    m_rreq.id      = 4'($urandom);
    m_rreq.data    = $urandom;
    m_rreq.attr    = 3'($urandom);
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      take_seen = s_creq_valid && !s_stall &&
                  (s_creq.typ == TYP_READ || (s_dreq_valid && s_dreq_attr[ATR_D_LAST]));
      if (t1_req.read || t1_req.write) pend.push_back(t1_req.seq);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
      end
    end
  end

  initial begin
    void'($urandom(32'h95e7_04a6));
    rst = 1'b1;
    s_creq_valid = 1'b0;
    s_creq = '0;
    s_dreq_valid = 1'b0;
    s_dreq_data = '0;
    s_dreq_attr = '0;
    t1_rsp = '0;
    t1_stall = 1'b0;
    t2_req = '0;
    t2_stall = 1'b0;
    m_creq_rdstall = 1'b0;
    m_creq_wrstall = 1'b0;
    m_dreq_stall = 1'b0;
    m_rreq_valid = 1'b0;
    m_rreq = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (accepted < NUM_CMDS) begin
      @(negedge clk);
      drive_cpu();
      drive_cache();
      drive_l2();
    end
    // Drain the miss FIFO with no new requests
    t1_rsp = '0;
    t2_req = '0;
    while (!mfifo_empty) begin
      @(negedge clk);
      drive_l2();
      t2_req = '0;
    end
    @(negedge clk);
    $display("Run done: %0d commands, %0d errors", accepted, i_checker.err_count);
    if (i_checker.err_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
cache_front_pkg.sv
sreq_decode.sv
seq_tracker.sv
mreq_fifo.sv
mreq_issue.sv
cache_front_top.sv
cache_front_properties.sv
cache_front_checker.sv
tb_cache_front.sv

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_cache_front -o sim_cache_front || exit 1

out=$(./obj_dir/sim_cache_front)
echo "$out"
echo "$out" | grep -qF '** PASS **' && exit 0 || exit 1
